/* verilog/periph_defs.svh */
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

`default_nettype none

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define PERIPH_ADDR_W 16
`define PERIPH_DATA_W 32

// Timer channels
`define PERIPH_N_TIMER 2

// ----------------------------------------------------------
// Interrupt controller sizing
// ----------------------------------------------------------
`define PERIPH_N_SRC 16
`define PERIPH_SRC_ID_W 4
`define PERIPH_PRIO_W 3
`define PERIPH_N_TGT 2
`define PERIPH_N_EVT 8

// 4 KiB regions, anything above falls to the error responder
`define PERIPH_TIMER_BASE 16'h0000
`define PERIPH_IRQ_BASE 16'h1000

`define PERIPH_ERR_DATA 32'hdeadbeef

`default_nettype wire

`endif

/* verilog/periph_bus_pkg.sv */
`include "periph_defs.svh"

`default_nettype none

package periph_bus_pkg;

    // Byte address on the APB side
    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;

    // One APB data word
    typedef logic [`PERIPH_DATA_W-1:0] data_t;

    // Decoded target of a transfer
    typedef enum logic [1:0] {
        TIMER,
        IRQ,
        NONE
    } region_e;

endpackage

`default_nettype wire

/* verilog/periph_irq_pkg.sv */
`include "periph_defs.svh"

`default_nettype none

package periph_irq_pkg;

    // One bit per interrupt source, bit 0 is never used
    typedef logic [`PERIPH_N_SRC-1:0] src_vec_t;

    // Source number, 0 means no interrupt
    typedef logic [`PERIPH_SRC_ID_W-1:0] src_id_t;

    // Priority 0 is never taken
    typedef logic [`PERIPH_PRIO_W-1:0] prio_t;

    // One bit per target
    typedef logic [`PERIPH_N_TGT-1:0] tgt_vec_t;

    // External event lines
    typedef logic [`PERIPH_N_EVT-1:0] evt_vec_t;

endpackage

`default_nettype wire

/* verilog/apb_decoder.sv */
`include "periph_defs.svh"

`default_nettype none

module apb_decoder (
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  periph_bus_pkg::addr_t paddr_i,
    input  periph_bus_pkg::data_t pwdata_i,
    output periph_bus_pkg::data_t prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  timer_sel_o,
    output logic                  irq_sel_o,
    input  periph_bus_pkg::data_t timer_rdata_i,
    input  periph_bus_pkg::data_t irq_rdata_i
);

    // Regions are 4 KiB, so the page number sits above bit 12
    localparam int region_lsb = 12;
    localparam int page_w = `PERIPH_ADDR_W - region_lsb;
    localparam periph_bus_pkg::addr_t timer_base = `PERIPH_TIMER_BASE;
    localparam periph_bus_pkg::addr_t irq_base = `PERIPH_IRQ_BASE;

    periph_bus_pkg::region_e region;
    logic [page_w-1:0]       page;
    logic                    access;

    assign page = paddr_i[`PERIPH_ADDR_W-1:region_lsb];
    assign access = psel_i & penable_i;

    always_comb begin
        if (page == timer_base[`PERIPH_ADDR_W-1:region_lsb]) begin
            region = periph_bus_pkg::TIMER;
        end else if (page == irq_base[`PERIPH_ADDR_W-1:region_lsb]) begin
            region = periph_bus_pkg::IRQ;
        end else begin
            region = periph_bus_pkg::NONE;
        end
    end

    // Selects follow psel through both phases
    assign timer_sel_o = psel_i & (region == periph_bus_pkg::TIMER);
    assign irq_sel_o   = psel_i & (region == periph_bus_pkg::IRQ);

    // ----------------------------------------------------------
    // Zero-wait response for every region
    // ----------------------------------------------------------
    assign pready_o  = access;
    assign pslverr_o = access & (region == periph_bus_pkg::NONE);

    always_comb begin
        case (region)
            periph_bus_pkg::TIMER: prdata_o = timer_rdata_i;
            periph_bus_pkg::IRQ:   prdata_o = irq_rdata_i;
            default:               prdata_o = `PERIPH_ERR_DATA;
        endcase
    end

    // Sampled at the start of each access phase
    a_one_hot_sel: assert property (@(posedge penable_i)
        psel_i |-> !(timer_sel_o && irq_sel_o));

    // Host keeps write data defined across the transfer
    a_wdata_known: assert property (@(posedge penable_i)
        (psel_i && pwrite_i) |-> !$isunknown(pwdata_i));

endmodule

`default_nettype wire

/* verilog/apb_timer.sv */
`include "periph_defs.svh"

`default_nettype none

module apb_timer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        sel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  periph_bus_pkg::addr_t       addr_i,
    input  periph_bus_pkg::data_t       wdata_i,
    output periph_bus_pkg::data_t       rdata_o,
    output logic [`PERIPH_N_TIMER-1:0]  irq_o
);

    localparam int n_ch = `PERIPH_N_TIMER;
    localparam int ch_w = (n_ch > 1) ? $clog2(n_ch) : 1;

    // Register index inside a 16-byte channel block
    localparam logic [1:0] reg_ctrl   = 2'd0;
    localparam logic [1:0] reg_count  = 2'd1;
    localparam logic [1:0] reg_cmp    = 2'd2;
    localparam logic [1:0] reg_status = 2'd3;

    logic [n_ch-1:0]       en_q;
    logic [n_ch-1:0]       ie_q;
    logic [n_ch-1:0]       status_q;
    periph_bus_pkg::data_t count_q [n_ch];
    periph_bus_pkg::data_t cmp_q [n_ch];

    logic [ch_w-1:0] chan;
    logic [1:0]      reg_idx;
    logic            hit;
    logic            wr_en;

    assign chan    = addr_i[4 +: ch_w];
    assign reg_idx = addr_i[3:2];
    assign hit     = (addr_i[11:4] < n_ch);
    assign wr_en   = sel_i & penable_i & pwrite_i & hit;

    // ----------------------------------------------------------
    // Counters and register writes
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q     <= '0;
            ie_q     <= '0;
            status_q <= '0;
            for (int c = 0; c < n_ch; c++) begin
                count_q[c] <= '0;
                cmp_q[c]   <= '0;
            end
        end else begin
            for (int c = 0; c < n_ch; c++) begin
                // Write-one-to-clear, a match in the same cycle wins
                if (wr_en && chan == ch_w'(c) && reg_idx == reg_status && wdata_i[0]) begin
                    status_q[c] <= 1'b0;
                end

                if (en_q[c]) begin
                    if (count_q[c] == cmp_q[c]) begin
                        count_q[c]  <= '0;
                        status_q[c] <= 1'b1;
                    end else begin
                        count_q[c] <= count_q[c] + 1'b1;
                    end
                end

                // Host write to COUNT overrides the increment
                if (wr_en && chan == ch_w'(c)) begin
                    case (reg_idx)
                        reg_ctrl: begin
                            en_q[c] <= wdata_i[0];
                            ie_q[c] <= wdata_i[1];
                        end
                        reg_count: count_q[c] <= wdata_i;
                        reg_cmp:   cmp_q[c] <= wdata_i;
                        default: ;
                    endcase
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Read side and interrupt lines
    // ----------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (hit) begin
            case (reg_idx)
                reg_ctrl:  rdata_o[1:0] = {ie_q[chan], en_q[chan]};
                reg_count: rdata_o = count_q[chan];
                reg_cmp:   rdata_o = cmp_q[chan];
                default:   rdata_o[0] = status_q[chan];
            endcase
        end
    end

    assign irq_o = status_q & ie_q;

    // A match can only come from a running channel
    a_status_needs_en: assert property (@(posedge clk_i) disable iff (rst_i)
        (status_q & ~$past(status_q) & ~$past(en_q)) == '0);

endmodule

`default_nettype wire

/* verilog/irq_controller.sv */
`include "periph_defs.svh"

`default_nettype none

module irq_controller (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     sel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  periph_bus_pkg::addr_t    addr_i,
    input  periph_bus_pkg::data_t    wdata_i,
    output periph_bus_pkg::data_t    rdata_o,
    input  periph_irq_pkg::src_vec_t src_i,
    output periph_irq_pkg::tgt_vec_t irq_o
);

    localparam int n_src = `PERIPH_N_SRC;
    localparam int n_tgt = `PERIPH_N_TGT;
    localparam int id_w = `PERIPH_SRC_ID_W;
    localparam int prio_w = `PERIPH_PRIO_W;
    localparam int tgt_w = (n_tgt > 1) ? $clog2(n_tgt) : 1;

    periph_irq_pkg::src_vec_t pending_q;
    periph_irq_pkg::src_vec_t in_serv_q;
    periph_irq_pkg::prio_t    prio_q [n_src];
    periph_irq_pkg::src_vec_t enable_q [n_tgt];
    periph_irq_pkg::prio_t    thresh_q [n_tgt];

    periph_irq_pkg::src_id_t  best_id [n_tgt];
    periph_irq_pkg::prio_t    best_prio [n_tgt];

    periph_irq_pkg::src_vec_t pending_d;
    periph_irq_pkg::src_vec_t in_serv_d;
    periph_irq_pkg::src_vec_t claim_mask;
    periph_irq_pkg::src_vec_t complete_mask;

    logic [11:0]             off;
    periph_irq_pkg::src_id_t prio_idx;
    logic [tgt_w-1:0]        en_tgt;
    logic [tgt_w-1:0]        ctl_tgt;
    logic                    prio_hit;
    logic                    pend_hit;
    logic                    en_hit;
    logic                    thr_hit;
    logic                    clm_hit;
    logic                    wr_en;
    logic                    rd_en;

    // ----------------------------------------------------------
    // Register decode
    // ----------------------------------------------------------
    assign off      = addr_i[11:0];
    assign prio_idx = off[2 +: id_w];
    assign en_tgt   = off[2 +: tgt_w];
    assign ctl_tgt  = off[4 +: tgt_w];

    assign prio_hit = (off[11:8] == 4'h0) && (off[7:2] < n_src);
    assign pend_hit = (off == 12'h080);
    assign en_hit   = (off[11:8] == 4'h1) && (off[7:2] < n_tgt);
    assign thr_hit  = (off[11:8] == 4'h2) && (off[7:4] < n_tgt) && (off[3:0] == 4'h0);
    assign clm_hit  = (off[11:8] == 4'h2) && (off[7:4] < n_tgt) && (off[3:0] == 4'h4);

    assign wr_en = sel_i & penable_i & pwrite_i;
    assign rd_en = sel_i & penable_i & ~pwrite_i;

    // Best candidate per target, ties go to the lowest ID
    always_comb begin
        for (int t = 0; t < n_tgt; t++) begin
            best_id[t]   = '0;
            best_prio[t] = thresh_q[t];
            for (int s = 1; s < n_src; s++) begin
                if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
                    best_id[t]   = periph_irq_pkg::src_id_t'(s);
                    best_prio[t] = prio_q[s];
                end
            end
            irq_o[t] = (best_id[t] != '0);
        end
    end

    // Claim on read, complete on write
    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        if (clm_hit && rd_en && best_id[ctl_tgt] != '0) begin
            claim_mask[best_id[ctl_tgt]] = 1'b1;
        end
        if (clm_hit && wr_en) begin
            complete_mask[wdata_i[id_w-1:0]] = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Level gateways
    // ----------------------------------------------------------
    always_comb begin
        pending_d    = (pending_q | (src_i & ~in_serv_q)) & ~claim_mask;
        pending_d[0] = 1'b0;
        in_serv_d    = (in_serv_q | claim_mask) & ~complete_mask;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= '0;
            in_serv_q <= '0;
            for (int s = 0; s < n_src; s++) begin
                prio_q[s] <= '0;
            end
            for (int t = 0; t < n_tgt; t++) begin
                enable_q[t] <= '0;
                thresh_q[t] <= '0;
            end
        end else begin
            pending_q <= pending_d;
            in_serv_q <= in_serv_d;
            // Source 0 keeps priority 0
            if (wr_en && prio_hit && prio_idx != '0) begin
                prio_q[prio_idx] <= wdata_i[prio_w-1:0];
            end
            if (wr_en && en_hit) begin
                enable_q[en_tgt] <= wdata_i[n_src-1:0];
            end
            if (wr_en && thr_hit) begin
                thresh_q[ctl_tgt] <= wdata_i[prio_w-1:0];
            end
        end
    end

    // ----------------------------------------------------------
    // Read data
    // ----------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (prio_hit) begin
            rdata_o[prio_w-1:0] = prio_q[prio_idx];
        end else if (pend_hit) begin
            rdata_o[n_src-1:0] = pending_q;
        end else if (en_hit) begin
            rdata_o[n_src-1:0] = enable_q[en_tgt];
        end else if (thr_hit) begin
            rdata_o[prio_w-1:0] = thresh_q[ctl_tgt];
        end else if (clm_hit) begin
            rdata_o[id_w-1:0] = best_id[ctl_tgt];
        end
    end

    a_no_src0: assert property (@(posedge clk_i) disable iff (rst_i)
        !pending_q[0]);

    // Claim moves a bit from pending to in service in one step
    a_pend_xor_serv: assert property (@(posedge clk_i) disable iff (rst_i)
        (pending_q & in_serv_q) == '0);

endmodule

`default_nettype wire

/* verilog/periph_top.sv */
`include "periph_defs.svh"

`default_nettype none

module periph_top (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  periph_bus_pkg::addr_t    paddr_i,
    input  periph_bus_pkg::data_t    pwdata_i,
    output periph_bus_pkg::data_t    prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    input  periph_irq_pkg::evt_vec_t evt_i,
    input  logic                     mbox_irq_i,
    output periph_irq_pkg::tgt_vec_t irq_o
);

    // Source map, index 0 means no interrupt
    localparam int timer_lsb = 1;
    localparam int evt_lsb = timer_lsb + `PERIPH_N_TIMER;
    localparam int mbox_idx = evt_lsb + `PERIPH_N_EVT;

    logic                       timer_sel;
    logic                       irq_sel;
    periph_bus_pkg::data_t      timer_rdata;
    periph_bus_pkg::data_t      irq_rdata;
    logic [`PERIPH_N_TIMER-1:0] timer_irq;
    periph_irq_pkg::src_vec_t   irq_src;

    assign irq_src[0] = 1'b0;
    assign irq_src[evt_lsb-1:timer_lsb] = timer_irq;
    assign irq_src[mbox_idx-1:evt_lsb] = evt_i;
    assign irq_src[mbox_idx] = mbox_irq_i;
    // Reserved
    assign irq_src[`PERIPH_N_SRC-1:mbox_idx+1] = '0;

    apb_decoder u_apb_decoder (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .timer_sel_o   ( timer_sel   ),
        .irq_sel_o     ( irq_sel     ),
        .timer_rdata_i ( timer_rdata ),
        .irq_rdata_i   ( irq_rdata   )
    );

    apb_timer u_apb_timer (
        .clk_i     ( clk_i       ),
        .rst_i     ( rst_i       ),
        .sel_i     ( timer_sel   ),
        .penable_i ( penable_i   ),
        .pwrite_i  ( pwrite_i    ),
        .addr_i    ( paddr_i     ),
        .wdata_i   ( pwdata_i    ),
        .rdata_o   ( timer_rdata ),
        .irq_o     ( timer_irq   )
    );

    irq_controller u_irq_controller (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .sel_i     ( irq_sel   ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .addr_i    ( paddr_i   ),
        .wdata_i   ( pwdata_i  ),
        .rdata_o   ( irq_rdata ),
        .src_i     ( irq_src   ),
        .irq_o     ( irq_o     )
    );

endmodule

`default_nettype wire

/* dv/periph_tb.sv */
`include "periph_defs.svh"

`default_nettype none

module periph_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int wait_limit = 500;
    localparam int ready_limit = 4;
    localparam string stim_path = "dv/periph_stim.txt";
    // First address past the interrupt controller region
    localparam periph_bus_pkg::addr_t map_end = `PERIPH_IRQ_BASE + 16'h1000;

    logic                     clk;
    logic                     rst;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    periph_bus_pkg::addr_t    paddr;
    periph_bus_pkg::data_t    pwdata;
    periph_bus_pkg::data_t    prdata;
    logic                     pready;
    logic                     pslverr;
    periph_irq_pkg::evt_vec_t evt;
    logic                     mbox_irq;
    periph_irq_pkg::tgt_vec_t irq;
    string                    test_name;

    periph_top u_periph_top (
        .clk_i      ( clk      ),
        .rst_i      ( rst      ),
        .psel_i     ( psel     ),
        .penable_i  ( penable  ),
        .pwrite_i   ( pwrite   ),
        .paddr_i    ( paddr    ),
        .pwdata_i   ( pwdata   ),
        .prdata_o   ( prdata   ),
        .pready_o   ( pready   ),
        .pslverr_o  ( pslverr  ),
        .evt_i      ( evt      ),
        .mbox_irq_i ( mbox_irq ),
        .irq_o      ( irq      )
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string what, input periph_bus_pkg::data_t exp,
                              input periph_bus_pkg::data_t act);
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_max(input string what, input periph_bus_pkg::data_t bound,
                             input periph_bus_pkg::data_t act);
        if (act > bound) begin
            $display("Error: %s expected at most %h actual %h", what, bound, act);
            abort_run();
        end
    endtask

    task automatic check_err(input string what, input bit exp, input bit act);
        if (act !== exp) begin
            $display("Error: %s pslverr expected %b actual %b", what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_irq(input string what, input periph_irq_pkg::tgt_vec_t exp,
                             input periph_irq_pkg::tgt_vec_t act);
        if (act !== exp) begin
            $display("Error: %s irq_o expected %b actual %b", what, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // APB driver
    // ------------------------------------------------------------
    // Starts and ends 1 ns after a rising edge
    task automatic apb_xfer(input logic wr, input periph_bus_pkg::addr_t addr,
                            input periph_bus_pkg::data_t wdata,
                            output periph_bus_pkg::data_t rdata, output logic err);
        int idle;
        int cycles;
        idle = int'($urandom % 4);
        repeat (idle) begin
            @(posedge clk);
            #1;
        end
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles = 0;
        @(negedge clk);
        while (pready !== 1'b1 && cycles < ready_limit) begin
            cycles++;
            @(negedge clk);
        end
        if (pready !== 1'b1) begin
            $display("Timeout in %s: pready never rose for address %h", test_name, addr);
            abort_run();
        end else begin
            rdata = prdata;
            err = pslverr;
            @(posedge clk);
            #1;
            psel = 1'b0;
            penable = 1'b0;
            pwrite = 1'b0;
        end
    endtask

    task automatic wait_irq(input periph_irq_pkg::tgt_vec_t exp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (irq !== exp && cycles < wait_limit) begin
            cycles++;
            @(negedge clk);
        end
        if (irq !== exp) begin
            $display("Timeout in %s: irq_o never reached %b", test_name, exp);
            abort_run();
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sample_irq(input periph_irq_pkg::tgt_vec_t exp);
        @(negedge clk);
        check_irq(test_name, exp, irq);
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------
    // Stimulus file interpreter
    // ------------------------------------------------------------
    initial begin
        int                    fd;
        string                 line;
        string                 cmd;
        string                 name_arg;
        string                 what;
        logic [31:0]           arg_a;
        logic [31:0]           arg_b;
        periph_bus_pkg::data_t rdata;
        logic                  err;

        void'($urandom(32'haf22));
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        evt = '0;
        mbox_irq = 1'b0;
        test_name = "setup";
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", stim_path);
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            cmd = "";
            arg_a = '0;
            arg_b = '0;
            void'($fgets(line, fd));
            void'($sscanf(line, "%s %h %h", cmd, arg_a, arg_b));
            what = $sformatf("%s %s %h", test_name, cmd, arg_a[15:0]);
            case (cmd)
                "test": begin
                    void'($sscanf(line, "%s %s", cmd, name_arg));
                    test_name = name_arg;
                end
                "write": begin
                    apb_xfer(1'b1, arg_a[15:0], arg_b, rdata, err);
                    check_err(what, arg_a[15:0] >= map_end, err);
                end
                "read": begin
                    apb_xfer(1'b0, arg_a[15:0], '0, rdata, err);
                    check_data(what, arg_b, rdata);
                    check_err(what, 1'b0, err);
                end
                "err": begin
                    apb_xfer(1'b0, arg_a[15:0], '0, rdata, err);
                    check_data(what, `PERIPH_ERR_DATA, rdata);
                    check_err(what, 1'b1, err);
                end
                "rdmax": begin
                    apb_xfer(1'b0, arg_a[15:0], '0, rdata, err);
                    check_max(what, arg_b, rdata);
                    check_err(what, 1'b0, err);
                end
                "event": begin
                    evt = arg_a[7:0];
                    mbox_irq = arg_b[0];
                end
                "wait": wait_irq(arg_a[1:0]);
                "irq": sample_irq(arg_a[1:0]);
                "", "#": ;
                default: begin
                    $display("Unknown stimulus command '%s'", cmd);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/periph_stim.txt */
# write addr data | read addr exp | err addr | rdmax addr max  (hex)
# event evt mbox | wait irq | irq irq | test name
test reset_state
irq 0
read 1080 0
read 1204 0
read 1214 0
test readback
write 0018 00000123
read 0018 00000123
write 1010 0000000d
read 1010 5
write 1000 7
read 1000 0
write 1100 0000fff0
read 1100 0000fff0
write 1210 3
read 1210 3
read 0020 0
read 1084 0
read 1300 0
test unmapped
err 2000
err fffc
write 2018 55
read 0018 00000123
test timer_compare
write 1008 1
write 1100 4
write 0018 6
write 0010 3
wait 1
write 0010 0
read 001c 1
write 001c 1
read 001c 0
rdmax 0014 6
read 1204 2
write 1204 2
irq 0
test priority_claim
write 100c 2
write 1014 6
write 1100 38
event 07 0
wait 1
read 1204 5
write 1204 5
write 1200 6
read 1080 38
read 1204 0
irq 0
write 1200 2
read 1204 5
read 1204 4
read 1204 0
write 1200 0
read 1204 3
event 00 0
write 1204 5
write 1204 4
write 1204 3
read 1080 0
test targets
write 102c 3
write 1104 800
write 1210 0
event 00 1
wait 2
read 1214 b
irq 0
read 1080 0
write 1214 b
wait 2
read 1080 800
event 00 0
read 1214 b
write 1214 b
irq 0

/* compile.f */
+incdir+verilog
verilog/periph_bus_pkg.sv
verilog/periph_irq_pkg.sv
verilog/apb_decoder.sv
verilog/apb_timer.sv
verilog/irq_controller.sv
verilog/periph_top.sv
dv/periph_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
